// ==== Bender.yml ====
package:
  name: traffic_gen

export_include_dirs:
  - common

sources:
  - common/traffic_pkg.sv
  - common/req_if.sv
  - src/addr_gen.sv
  - traffic_gen/traffic_seq.sv
  - traffic_gen/rd_issuer.sv
  - traffic_gen/wr_issuer.sv
  - traffic_gen/traffic_gen_top.sv
  - target: test
    files:
      - verification/tb_axi_sink.sv
      - verification/tb_traffic_gen.sv

// ==== common/req_if.sv ====
// Single request handoff from the sequencer to an issuer.
// Transfer on valid && ready; payload must stay stable while valid waits.
`timescale 1ns/1ps

interface req_if
    import traffic_pkg::*;
();

    logic  valid;
    logic  ready;
    addr_t addr;
    user_t user;
    id_t   id;

    // sequencer side
    modport src (
        output valid,
        output addr,
        output user,
        output id,
        input  ready
    );

    // issuer side
    modport dst (
        input  valid,
        input  addr,
        input  user,
        input  id,
        output ready
    );

endinterface

// ==== common/traffic_consts.svh ====
// Width and code constants of the traffic generator.
// Line shift and data width must stay consistent (512-bit line = 64 bytes).
// Test-case bounds cover the kept read (1-9) and write (10-18) cases only.
`ifndef TRAFFIC_CONSTS_SVH
`define TRAFFIC_CONSTS_SVH

// bus field widths
`define TG_ADDR_W       64
`define TG_ID_W         12
`define TG_USER_W       6
`define TG_DATA_W       512

`define TG_LINE_SHIFT   6   // 64-byte cache line

// internal widths
`define TG_CNT_W        16
`define TG_CASE_W       8
`define TG_SEED_W       64

// test-case bounds
`define TG_RD_FIRST     1
`define TG_RD_LAST      9
`define TG_WR_FIRST     10
`define TG_WR_LAST      18

// user code layout: target in 5:4, zero in 3:2, coherence type in 1:0
`define TG_USER_ZERO    2'b00

`endif

// ==== common/traffic_pkg.sv ====
// Shared types of the traffic generator.
// The range, target and coherence-type encodings follow the user-code
// layout of the memory device; op_e values carry different meanings for
// reads and writes.
`include "traffic_consts.svh"

package traffic_pkg;

    typedef logic [`TG_ADDR_W-1:0]   addr_t;
    typedef logic [`TG_ID_W-1:0]     id_t;
    typedef logic [`TG_USER_W-1:0]   user_t;
    typedef logic [`TG_DATA_W-1:0]   data_t;
    typedef logic [`TG_DATA_W/8-1:0] strb_t;    // one strobe per byte
    typedef logic [`TG_CNT_W-1:0]    cnt_t;
    typedef logic [`TG_CASE_W-1:0]   case_t;
    typedef logic [`TG_SEED_W-1:0]   seed_t;

    // address window selector, unknown codes act as 32K
    typedef enum logic [2:0] {
        RANGE_32K  = 3'd1,  // 9 seed bits
        RANGE_128K = 3'd2,  // 11 seed bits
        RANGE_1M   = 3'd3,  // 14 seed bits
        RANGE_4M   = 3'd4,  // 16 seed bits
        RANGE_16M  = 3'd5,  // 18 seed bits
        RANGE_32M  = 3'd6   // 19 seed bits
    } range_e;

    // memory target, user bits 5:4
    typedef enum logic [1:0] {
        TGT_HOST      = 2'b00,
        TGT_DEV_BIAS  = 2'b11,  // device memory, device bias
        TGT_HOST_BIAS = 2'b10   // device memory, host bias
    } target_e;

    // coherence type, user bits 1:0
    typedef enum logic [1:0] {
        OP_NC           = 2'b00,    // non-cacheable, both directions
        OP_RD_CS_WR_CO  = 2'b01,    // read cacheable-shared / write cacheable-owned
        OP_RD_CO_WR_NCP = 2'b10     // read cacheable-owned / write nc-push
    } op_e;

endpackage

// ==== compile.f ====
+incdir+common
common/traffic_pkg.sv
common/req_if.sv
src/addr_gen.sv
traffic_gen/traffic_seq.sv
traffic_gen/rd_issuer.sv
traffic_gen/wr_issuer.sv
traffic_gen/traffic_gen_top.sv
verification/tb_axi_sink.sv
verification/tb_traffic_gen.sv

// ==== src/addr_gen.sv ====
// Pseudo-random line-aligned address source.
// Seed steps as s ^ (s << 1) ^ (s >> 1); a zero seed stays zero forever.
// The address is combinational from the seed register and the window inputs.
`timescale 1ns/1ps
`include "traffic_consts.svh"

module addr_gen
    import traffic_pkg::*;
(
    input  logic   axi4_mm_clk,
    input  logic   rst_n,
    input  logic   load,
    input  logic   advance,
    input  seed_t  seed_init,
    input  range_e range_sel,
    input  addr_t  page_addr,
    output addr_t  addr
);

    seed_t      seed;
    logic [4:0] keep_bits;  // random bits kept for the window
    seed_t      offset;

    always_ff @(posedge axi4_mm_clk or negedge rst_n) begin
        if (!rst_n) begin
            seed <= '0;
        end else if (load) begin
            seed <= seed_init;
        end else if (advance) begin
            seed <= seed ^ (seed << 1) ^ (seed >> 1);
        end
    end

    always_comb begin
        case (range_sel)
            RANGE_128K: keep_bits = 5'd11;
            RANGE_1M:   keep_bits = 5'd14;
            RANGE_4M:   keep_bits = 5'd16;
            RANGE_16M:  keep_bits = 5'd18;
            RANGE_32M:  keep_bits = 5'd19;
            default:    keep_bits = 5'd9;   // 32K and unknown codes
        endcase
        offset = seed & ((seed_t'(1) << keep_bits) - seed_t'(1));
    end

    // line-aligned offset above the page
    assign addr = page_addr + addr_t'(offset << `TG_LINE_SHIFT);

endmodule

// ==== traffic_gen/rd_issuer.sv ====
// AR channel issuer with a single request slot.
// Accepts a new request only when empty, so at most one read is outstanding.
`timescale 1ns/1ps

module rd_issuer
    import traffic_pkg::*;
(
    input  logic axi4_mm_clk,
    input  logic rst_n,
    req_if.dst   req,
    input  logic arready,
    output logic arvalid,
    output addr_t araddr,
    output id_t  arid,
    output user_t aruser
);

    logic full;

    assign req.ready = !full;

    always_ff @(posedge axi4_mm_clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
            arid <= '0;
        end else if (!full) begin
            if (req.valid) begin
                full <= 1'b1;
                arid <= req.id;
            end
        end else if (arready) begin
            full <= 1'b0;   // AR accepted
        end
    end

    // payload held while the slot is full
    always_ff @(posedge axi4_mm_clk) begin
        if (!full && req.valid) begin
            araddr <= req.addr;
            aruser <= req.user;
        end
    end

    assign arvalid = full;

endmodule

// ==== traffic_gen/traffic_gen_top.sv ====
// AXI4 memory-traffic generator top.
// Issues num_request reads or writes to random lines in a window above
// page_addr. Responses are not tracked; rready and bready are tied high.
// addr_range codes other than 1-6 select the 32K window.
`timescale 1ns/1ps

module traffic_gen_top
    import traffic_pkg::*;
(
    input  logic       axi4_mm_clk,
    input  logic       rst_n,
    input  logic       start,
    input  case_t      test_case,
    input  cnt_t       num_request,
    input  logic [2:0] addr_range,
    input  addr_t      page_addr,
    input  seed_t      seed_init,
    input  logic       arready,
    input  logic       awready,
    input  logic       wready,
    output logic       arvalid,
    output addr_t      araddr,
    output id_t        arid,
    output user_t      aruser,
    output logic       awvalid,
    output addr_t      awaddr,
    output id_t        awid,
    output user_t      awuser,
    output logic       wvalid,
    output data_t      wdata,
    output strb_t      wstrb,
    output logic       wlast,
    output logic       rready,
    output logic       bready,
    output logic       busy,
    output logic       done
);

    req_if rd_req ();
    req_if wr_req ();

    assign rready = 1'b1;
    assign bready = 1'b1;

    traffic_seq u_seq (
        .axi4_mm_clk (axi4_mm_clk),
        .rst_n       (rst_n),
        .start       (start),
        .test_case   (test_case),
        .num_request (num_request),
        .range_sel   (range_e'(addr_range)),    // raw code, unknown values allowed
        .page_addr   (page_addr),
        .seed_init   (seed_init),
        .rd_req      (rd_req.src),
        .wr_req      (wr_req.src),
        .busy        (busy),
        .done        (done)
    );

    rd_issuer u_rd (
        .axi4_mm_clk (axi4_mm_clk),
        .rst_n       (rst_n),
        .req         (rd_req.dst),
        .arready     (arready),
        .arvalid     (arvalid),
        .araddr      (araddr),
        .arid        (arid),
        .aruser      (aruser)
    );

    wr_issuer u_wr (
        .axi4_mm_clk (axi4_mm_clk),
        .rst_n       (rst_n),
        .req         (wr_req.dst),
        .awready     (awready),
        .wready      (wready),
        .awvalid     (awvalid),
        .awaddr      (awaddr),
        .awid        (awid),
        .awuser      (awuser),
        .wvalid      (wvalid),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wlast       (wlast)
    );

endmodule

// ==== traffic_gen/traffic_seq.sv ====
// Request sequencer: one run per accepted start.
// Starts with a case outside 1-18 or a zero count are ignored, as are
// starts while a run is in progress. Done waits for the issuer to drain.
`timescale 1ns/1ps
`include "traffic_consts.svh"

module traffic_seq
    import traffic_pkg::*;
(
    input  logic   axi4_mm_clk,
    input  logic   rst_n,
    input  logic   start,
    input  case_t  test_case,
    input  cnt_t   num_request,
    input  range_e range_sel,
    input  addr_t  page_addr,
    input  seed_t  seed_init,
    req_if.src     rd_req,
    req_if.src     wr_req,
    output logic   busy,
    output logic   done
);

    typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_DRAIN, ST_DONE} state_e;

    state_e  state;
    logic    start_ok;
    logic    dec_wr;
    case_t   dec_idx;    // position 0..8 inside the direction
    target_e dec_tgt;
    op_e     dec_op;
    logic    wr_q;
    user_t   user_q;
    cnt_t    num_q;
    cnt_t    cnt_q;
    id_t     id_q;
    range_e  range_q;
    addr_t   page_q;
    addr_t   req_addr;
    logic    xfer;
    logic    sel_ready;

    always_comb begin
        dec_wr  = (test_case >= case_t'(`TG_WR_FIRST));
        dec_idx = dec_wr ? test_case - case_t'(`TG_WR_FIRST) : test_case - case_t'(`TG_RD_FIRST);
        case (dec_idx)
            8'd0, 8'd1, 8'd2: dec_tgt = TGT_HOST;
            8'd3, 8'd4, 8'd5: dec_tgt = TGT_DEV_BIAS;
            default:          dec_tgt = TGT_HOST_BIAS;
        endcase
        case (dec_idx)
            8'd0, 8'd3, 8'd6: dec_op = OP_NC;
            8'd1, 8'd4, 8'd7: dec_op = dec_wr ? OP_RD_CS_WR_CO : OP_RD_CO_WR_NCP;
            default:          dec_op = dec_wr ? OP_RD_CO_WR_NCP : OP_RD_CS_WR_CO;
        endcase
    end

    assign start_ok = start && (state == ST_IDLE || state == ST_DONE)
                    && test_case >= case_t'(`TG_RD_FIRST)
                    && test_case <= case_t'(`TG_WR_LAST)
                    && num_request != '0;

    always_ff @(posedge axi4_mm_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            wr_q  <= 1'b0;
            cnt_q <= '0;
            id_q  <= '0;
        end else begin
            case (state)
                ST_IDLE, ST_DONE: begin
                    if (start_ok) begin
                        state <= ST_RUN;
                        wr_q  <= dec_wr;
                        cnt_q <= '0;
                        id_q  <= '0;    // ids restart each run
                    end
                end
                ST_RUN: begin
                    if (xfer) begin
                        cnt_q <= cnt_q + cnt_t'(1);
                        id_q  <= id_q + id_t'(1);
                        if (cnt_q == num_q - cnt_t'(1)) begin
                            state <= ST_DRAIN;
                        end
                    end
                end
                ST_DRAIN: begin
                    if (sel_ready) begin
                        state <= ST_DONE;   // issuer empty again
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // run parameters, captured once per start
    always_ff @(posedge axi4_mm_clk) begin
        if (start_ok) begin
            user_q  <= user_t'({dec_tgt, `TG_USER_ZERO, dec_op});
            num_q   <= num_request;
            range_q <= range_sel;
            page_q  <= page_addr;
        end
    end

    addr_gen u_addr_gen (
        .axi4_mm_clk (axi4_mm_clk),
        .rst_n       (rst_n),
        .load        (start_ok),
        .advance     (xfer),
        .seed_init   (seed_init),
        .range_sel   (range_q),
        .page_addr   (page_q),
        .addr        (req_addr)
    );

    assign sel_ready = wr_q ? wr_req.ready : rd_req.ready;
    assign xfer      = (state == ST_RUN) && sel_ready;

    assign rd_req.valid = (state == ST_RUN) && !wr_q;
    assign rd_req.addr  = req_addr;
    assign rd_req.user  = user_q;
    assign rd_req.id    = id_q;

    assign wr_req.valid = (state == ST_RUN) && wr_q;
    assign wr_req.addr  = req_addr;
    assign wr_req.user  = user_q;
    assign wr_req.id    = id_q;

    assign busy = (state == ST_RUN) || (state == ST_DRAIN);
    assign done = (state == ST_DONE);

endmodule

// ==== traffic_gen/wr_issuer.sv ====
// AW/W channel issuer with a single request slot.
// Address and data are raised together and complete independently; the
// slot frees once both have been accepted. Single-beat full-line writes only.
`timescale 1ns/1ps

module wr_issuer
    import traffic_pkg::*;
(
    input  logic  axi4_mm_clk,
    input  logic  rst_n,
    req_if.dst    req,
    input  logic  awready,
    input  logic  wready,
    output logic  awvalid,
    output addr_t awaddr,
    output id_t   awid,
    output user_t awuser,
    output logic  wvalid,
    output data_t wdata,
    output strb_t wstrb,
    output logic  wlast
);

    logic aw_pend;
    logic w_pend;
    logic take;

    assign req.ready = !aw_pend && !w_pend;
    assign take      = req.ready && req.valid;

    always_ff @(posedge axi4_mm_clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_pend <= 1'b0;
            awid    <= '0;
        end else if (take) begin
            aw_pend <= 1'b1;
            awid    <= req.id;
        end else if (aw_pend && awready) begin
            aw_pend <= 1'b0;
        end
    end

    always_ff @(posedge axi4_mm_clk or negedge rst_n) begin
        if (!rst_n) begin
            w_pend <= 1'b0;
        end else if (take) begin
            w_pend <= 1'b1;
        end else if (w_pend && wready) begin
            w_pend <= 1'b0;
        end
    end

    always_ff @(posedge axi4_mm_clk) begin
        if (take) begin
            awaddr <= req.addr;
            awuser <= req.user;
        end
    end

    assign awvalid = aw_pend;
    assign wvalid  = w_pend;

    // all-ones line with every byte enabled, zero between beats
    assign wdata = w_pend ? '1 : '0;
    assign wstrb = w_pend ? '1 : '0;
    assign wlast = w_pend;  // single-beat burst

endmodule

// ==== verification/tb_axi_sink.sv ====
// AXI slave stand-in for the generator's AR, AW and W channels.
// Readies are random, independent of valid, and high about 3 cycles in 4.
// Responses are not modeled; only handshakes are counted.
`timescale 1ns/1ps

module tb_axi_sink (
    input  logic axi4_mm_clk,
    input  logic rst_n,
    input  logic arvalid,
    input  logic awvalid,
    input  logic wvalid,
    output logic arready,
    output logic awready,
    output logic wready,
    output int   ar_count,
    output int   aw_count,
    output int   w_count
);

    integer      seed;
    logic [31:0] draw;

    initial begin
        seed     = 32'h2885;
        arready  = 1'b0;
        awready  = 1'b0;
        wready   = 1'b0;
        ar_count = 0;
        aw_count = 0;
        w_count  = 0;
    end

    always @(posedge axi4_mm_clk) begin
        draw = $random(seed);
        arready <= draw[0] | draw[1];
        awready <= draw[2] | draw[3];
        wready  <= draw[4] | draw[5];
        if (rst_n && arvalid && arready) ar_count <= ar_count + 1;
        if (rst_n && awvalid && awready) aw_count <= aw_count + 1;
        if (rst_n && wvalid && wready)   w_count  <= w_count + 1;
    end

endmodule

// ==== verification/tb_traffic_gen.sv ====
// Testbench for traffic_gen_top: a table of runs applied in order.
// Expected addresses come from the seed step and window rules; every handshake
// is checked at the falling edge. Stops at the first mismatch.
`timescale 1ns/1ps
`include "traffic_consts.svh"

module tb_traffic_gen
    import traffic_pkg::*;
();

    typedef struct packed {
        case_t      tc;
        cnt_t       num;
        logic [2:0] rng;
        addr_t      page;
        seed_t      seed;
        user_t      user;
    } row_t;

    localparam int NUM_ROWS = 21;

    logic axi4_mm_clk, rst_n, start, arready, awready, wready;
    case_t test_case;
    cnt_t num_request;
    logic [2:0] addr_range;
    addr_t page_addr, araddr, awaddr;
    seed_t seed_init;
    logic arvalid, awvalid, wvalid, wlast, rready, bready, busy, done;
    id_t arid, awid;
    user_t aruser, awuser;
    data_t wdata;
    strb_t wstrb;
    int ar_count, aw_count, w_count;

    row_t rows [NUM_ROWS];
    int cycles, limit;
    logic row_live, cur_wr;     // what the monitor expects in this row
    user_t cur_user;
    addr_t cur_page;
    logic [2:0] cur_rng;
    seed_t ar_seed, aw_seed;    // model seeds, one per channel
    int ar_n, aw_n;
    logic ar_wait, aw_wait, w_wait;
    addr_t held_araddr, held_awaddr;
    id_t held_arid, held_awid;
    user_t held_aruser, held_awuser;

    traffic_gen_top dut (.*);

    tb_axi_sink sink (.*);

    initial begin
        axi4_mm_clk = 1'b0;
        forever #2 axi4_mm_clk = ~axi4_mm_clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic addr_cmp(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) abort_run($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic user_cmp(input string name, input user_t got, input user_t exp);
        if (got !== exp) abort_run($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic id_cmp(input string name, input id_t got, input id_t exp);
        if (got !== exp) abort_run($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic data_cmp(input string name, input data_t got, input data_t exp);
        if (got !== exp) abort_run($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic strb_cmp(input string name, input strb_t got, input strb_t exp);
        if (got !== exp) abort_run($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic cnt_cmp(input string name, input cnt_t got, input cnt_t exp);
        if (got !== exp) abort_run($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic flag_cmp(input string name, input logic got, input logic exp);
        if (got !== exp) abort_run($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // random seed bits kept per window code
    function automatic int window_bits(input logic [2:0] rng);
        case (rng)
            3'd2:    return 11;
            3'd3:    return 14;
            3'd4:    return 16;
            3'd5:    return 18;
            3'd6:    return 19;
            default: return 9;
        endcase
    endfunction

    function automatic seed_t next_seed(input seed_t s);
        return s ^ (s << 1) ^ (s >> 1);
    endfunction

    function automatic addr_t expected_addr(input seed_t s);
        seed_t mask;
        mask = (seed_t'(1) << window_bits(cur_rng)) - seed_t'(1);
        return cur_page + ((s & mask) << `TG_LINE_SHIFT);
    endfunction

    task automatic window_check(input string name, input addr_t a);
        addr_t off;
        off = a - cur_page;
        if (off >= (addr_t'(1) << (window_bits(cur_rng) + `TG_LINE_SHIFT)) || off[5:0] != 6'd0)
            abort_run($sformatf("%s offset 0x%h is outside the window or not line aligned",
                                name, off));
    endtask

    always @(posedge axi4_mm_clk) begin
        cycles = cycles + 1;
        if (cycles > limit) abort_run($sformatf("timeout after %0d cycles", cycles));
    end

    // handshake monitor, outputs are stable at the falling edge
    always @(negedge axi4_mm_clk) begin
        if (rst_n) begin
            if (done && busy) abort_run("busy and done are high together");
            flag_cmp("rready", rready, 1'b1);
            flag_cmp("bready", bready, 1'b1);
            if (ar_wait) begin
                flag_cmp("arvalid", arvalid, 1'b1);     // valid held until ready
                addr_cmp("araddr", araddr, held_araddr);
                id_cmp("arid", arid, held_arid);
                user_cmp("aruser", aruser, held_aruser);
            end
            if (aw_wait) begin
                flag_cmp("awvalid", awvalid, 1'b1);
                addr_cmp("awaddr", awaddr, held_awaddr);
                id_cmp("awid", awid, held_awid);
                user_cmp("awuser", awuser, held_awuser);
            end
            if (w_wait) flag_cmp("wvalid", wvalid, 1'b1);
            if (arvalid && arready) begin
                if (!row_live || cur_wr) abort_run("unexpected AR handshake in this row");
                window_check("araddr", araddr);
                addr_cmp("araddr", araddr, expected_addr(ar_seed));
                id_cmp("arid", arid, id_t'(ar_n));
                user_cmp("aruser", aruser, cur_user);
                ar_seed = next_seed(ar_seed);
                ar_n = ar_n + 1;
            end
            if (awvalid && awready) begin
                if (!row_live || !cur_wr) abort_run("unexpected AW handshake in this row");
                window_check("awaddr", awaddr);
                addr_cmp("awaddr", awaddr, expected_addr(aw_seed));
                id_cmp("awid", awid, id_t'(aw_n));
                user_cmp("awuser", awuser, cur_user);
                aw_seed = next_seed(aw_seed);
                aw_n = aw_n + 1;
            end
            if (wvalid && wready) begin
                if (!row_live || !cur_wr) abort_run("unexpected W handshake in this row");
                data_cmp("wdata", wdata, '1);
                strb_cmp("wstrb", wstrb, '1);
                flag_cmp("wlast", wlast, 1'b1);
            end
            if (!wvalid) begin
                data_cmp("wdata", wdata, '0);   // zero between beats
                strb_cmp("wstrb", wstrb, '0);
            end
        end
        ar_wait = rst_n && arvalid && !arready;
        aw_wait = rst_n && awvalid && !awready;
        w_wait  = rst_n && wvalid && !wready;
        held_araddr = araddr;
        held_arid   = arid;
        held_aruser = aruser;
        held_awaddr = awaddr;
        held_awid   = awid;
        held_awuser = awuser;
    end

    task automatic run_row(input row_t r);
        logic live;
        int ar0;
        int aw0;
        int w0;
        live = r.tc >= 1 && r.tc <= 18 && r.num != 0;   // only these starts are taken
        @(posedge axi4_mm_clk);
        ar0 = ar_count;
        aw0 = aw_count;
        w0 = w_count;
        row_live = live;
        cur_wr = r.tc >= 10;
        cur_user = r.user;
        cur_page = r.page;
        cur_rng = r.rng;
        ar_seed = r.seed;
        aw_seed = r.seed;
        ar_n = 0;
        aw_n = 0;
        start <= 1'b1;
        test_case <= r.tc;
        num_request <= r.num;
        addr_range <= r.rng;
        page_addr <= r.page;
        seed_init <= r.seed;
        @(posedge axi4_mm_clk);
        start <= 1'b0;
        @(negedge axi4_mm_clk);
        flag_cmp("busy", busy, live);
        if (live) begin
            flag_cmp("done", done, 1'b0);
            while (!done) begin
                flag_cmp("busy", busy, 1'b1);   // busy until done
                @(negedge axi4_mm_clk);
            end
        end else begin
            repeat (8) @(negedge axi4_mm_clk) flag_cmp("busy", busy, 1'b0);
        end
        cnt_cmp("AR handshakes", cnt_t'(ar_count - ar0), (live && !cur_wr) ? r.num : cnt_t'(0));
        cnt_cmp("AW handshakes", cnt_t'(aw_count - aw0), (live && cur_wr) ? r.num : cnt_t'(0));
        cnt_cmp("W handshakes", cnt_t'(w_count - w0), (live && cur_wr) ? r.num : cnt_t'(0));
    endtask

    initial begin
        rst_n = 1'b0;
        start = 1'b0;
        test_case = '0;
        num_request = '0;
        addr_range = 3'd0;
        page_addr = '0;
        seed_init = '0;
        cycles = 0;
        row_live = 1'b0;
        cur_wr = 1'b0;
        // test case, count, window, page, seed, expected user code
        rows[0]  = '{8'd1,  16'd6,  3'd1, 64'h0000_0001_0000_0000, 64'h0123_4567_89ab_cdef, 6'h00};
        rows[1]  = '{8'd2,  16'd5,  3'd2, 64'h0000_0002_0000_0000, 64'h0000_0000_0000_0001, 6'h02};
        rows[2]  = '{8'd3,  16'd8,  3'd3, 64'h0000_0003_0000_0000, 64'hdead_beef_cafe_f00d, 6'h01};
        rows[3]  = '{8'd4,  16'd4,  3'd4, 64'h0000_0040_0000_0000, 64'h8000_0000_0000_0001, 6'h30};
        rows[4]  = '{8'd5,  16'd7,  3'd5, 64'h0000_0041_0000_0000, 64'h5555_aaaa_5555_aaaa, 6'h32};
        rows[5]  = '{8'd6,  16'd6,  3'd6, 64'h0000_0042_0000_0000, 64'h0f0f_0f0f_f0f0_f0f0, 6'h31};
        rows[6]  = '{8'd7,  16'd5,  3'd7, 64'h0000_0050_0000_0000, 64'h1357_9bdf_2468_ace0, 6'h20};
        rows[7]  = '{8'd8,  16'd9,  3'd1, 64'h0000_0051_0000_0000, 64'h0000_0000_0007_ffff, 6'h22};
        rows[8]  = '{8'd9,  16'd4,  3'd0, 64'h0000_0052_0000_0000, 64'hffff_ffff_ffff_ffff, 6'h21};
        rows[9]  = '{8'd10, 16'd6,  3'd1, 64'h0000_0080_0000_0000, 64'h0bad_c0de_1234_5678, 6'h00};
        rows[10] = '{8'd11, 16'd5,  3'd2, 64'h0000_0081_0000_0000, 64'h7777_0000_3333_1111, 6'h01};
        rows[11] = '{8'd12, 16'd7,  3'd3, 64'h0000_0082_0000_0000, 64'h0000_0000_0000_0100, 6'h02};
        rows[12] = '{8'd13, 16'd4,  3'd4, 64'h0000_00c0_0000_0000, 64'h2468_0000_0000_9999, 6'h30};
        rows[13] = '{8'd14, 16'd8,  3'd5, 64'h0000_00c1_0000_0000, 64'hface_b00c_0000_4321, 6'h31};
        rows[14] = '{8'd15, 16'd5,  3'd6, 64'h0000_00c2_0000_0000, 64'h0000_ffff_0000_ffff, 6'h32};
        rows[15] = '{8'd16, 16'd6,  3'd7, 64'h0000_00d0_0000_0000, 64'h1111_2222_3333_4444, 6'h20};
        rows[16] = '{8'd17, 16'd4,  3'd0, 64'h0000_00d1_0000_0000, 64'h9abc_def0_0fed_cba9, 6'h21};
        rows[17] = '{8'd18, 16'd10, 3'd3, 64'h0000_00d2_0000_0000, 64'h0000_0001_8000_0000, 6'h22};
        rows[18] = '{8'd0,  16'd5,  3'd1, 64'h0000_0100_0000_0000, 64'h0000_0000_0000_00ff, 6'h00};
        rows[19] = '{8'd40, 16'd5,  3'd1, 64'h0000_0100_0000_0000, 64'h0000_0000_0000_00ff, 6'h00};
        rows[20] = '{8'd2,  16'd0,  3'd1, 64'h0000_0100_0000_0000, 64'h0000_0000_0000_00ff, 6'h00};
        limit = 100 * NUM_ROWS;
        for (int i = 0; i < NUM_ROWS; i++) limit = limit + 8 * int'(rows[i].num);
        repeat (9) @(posedge axi4_mm_clk);
        @(negedge axi4_mm_clk);
        flag_cmp("arvalid", arvalid, 1'b0);     // reset values
        flag_cmp("awvalid", awvalid, 1'b0);
        flag_cmp("wvalid", wvalid, 1'b0);
        flag_cmp("busy", busy, 1'b0);
        flag_cmp("done", done, 1'b0);
        id_cmp("arid", arid, '0);
        id_cmp("awid", awid, '0);
        @(posedge axi4_mm_clk);
        rst_n <= 1'b1;
        for (int i = 0; i < NUM_ROWS; i++) run_row(rows[i]);
        $display(">>> PASS");
        $finish;
    end

endmodule
